/* design/lsu_pkg.sv */
package lsu_pkg;

    localparam int XLEN         = 32;
    localparam int DMEM_WORDS   = 256;  // Word index from address bits 9:2
    localparam int DMEM_LATENCY = 2;    // Req rise to ack rise, in cycles

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 size and signedness
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;  // Loads only
    localparam logic [2:0] F3_HU = 3'b101;  // Loads only

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    localparam logic [1:0] FAULT_NONE       = 2'd0;
    localparam logic [1:0] FAULT_ILLEGAL    = 2'd1;  // Opcode or funct3
    localparam logic [1:0] FAULT_MISALIGNED = 2'd2;

    // Request stage FSM
    localparam logic [1:0] REQ_IDLE     = 2'd0;  // Empty, fault entry or bubble
    localparam logic [1:0] REQ_WAIT_ACK = 2'd1;  // req high
    localparam logic [1:0] REQ_WAIT_LOW = 2'd2;  // req dropped, ack falling

    // One instruction word, I-type and S-type views
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } ld;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } st;
    } lsu_instr_u;

endpackage

/* design/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_valid,
    input  logic [XLEN-1:0] cmd_instr,
    input  logic [XLEN-1:0] cmd_rs1_val,
    input  logic [XLEN-1:0] cmd_rs2_val,
    input  logic            mem_stall,
    input  logic            pend_req_valid,
    input  logic [4:0]      pend_req_rd,
    input  logic            fwd_rsp_valid,
    input  logic [4:0]      fwd_rsp_rd,
    input  logic            fwd_wb_valid,
    input  logic [4:0]      fwd_wb_rd,
    output logic            cmd_ready,
    output logic            d_valid,
    output logic            d_is_store,
    output logic [1:0]      d_size,
    output logic            d_signed,
    output logic [XLEN-1:0] d_addr,
    output logic [4:0]      d_rd,
    output logic [4:0]      d_rs2,
    output logic [XLEN-1:0] d_rs2_val,
    output logic [1:0]      d_fault
);
    lsu_instr_u      instr;
    logic            is_load;
    logic            is_store;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] addr;
    logic [1:0]      size;
    logic            sgn;
    logic            f3_ok;
    logic [1:0]      fault;
    logic            own_pend;
    logic            rs1_haz;
    logic            rs2_haz;

    assign instr    = cmd_instr;
    assign is_load  = instr.ld.opcode == OPC_LOAD;
    assign is_store = instr.st.opcode == OPC_STORE;
    assign rs1      = instr.ld.rs1;  // Same bits in both views
    assign rs2      = instr.st.rs2;

    // S-type immediate sits on both sides of rs2
    assign imm  = is_store ? {{20{instr.st.imm_hi[6]}}, instr.st.imm_hi, instr.st.imm_lo}
                           : {{20{instr.ld.imm[11]}}, instr.ld.imm};
    assign addr = cmd_rs1_val + imm;

    always_comb begin
        size  = SIZE_WORD;
        sgn   = 1'b1;
        f3_ok = 1'b1;
        case (instr.ld.funct3)
            F3_B:  size = SIZE_BYTE;
            F3_H:  size = SIZE_HALF;
            F3_W:  size = SIZE_WORD;
            F3_BU: begin
                size  = SIZE_BYTE;
                sgn   = 1'b0;
                f3_ok = is_load;  // No unsigned store
            end
            F3_HU: begin
                size  = SIZE_HALF;
                sgn   = 1'b0;
                f3_ok = is_load;
            end
            default: f3_ok = 1'b0;
        endcase

        if (!(is_load || is_store) || !f3_ok)
            fault = FAULT_ILLEGAL;
        else if ((size == SIZE_HALF && addr[0]) || (size == SIZE_WORD && addr[1:0] != 2'b00))
            fault = FAULT_MISALIGNED;
        else
            fault = FAULT_NONE;
    end

    // Load still held here, one cycle ahead of the request stage
    assign own_pend = d_valid && !d_is_store && d_fault == FAULT_NONE;

    // Base register still being loaded somewhere down the pipe
    assign rs1_haz = rs1 != 5'd0 && ((own_pend && d_rd == rs1) ||
                                     (pend_req_valid && pend_req_rd == rs1) ||
                                     (fwd_rsp_valid && fwd_rsp_rd == rs1) ||
                                     (fwd_wb_valid && fwd_wb_rd == rs1));

    // Store data from a load gone before this store reaches its forwarding mux
    // Loads past the request stage always qualify
    // One still in the request stage qualifies when a clean access waits in decode
    assign rs2_haz = is_store && rs2 != 5'd0 &&
                     ((pend_req_valid && pend_req_rd == rs2 &&
                       d_valid && d_fault == FAULT_NONE) ||
                      (fwd_rsp_valid && fwd_rsp_rd == rs2) ||
                      (fwd_wb_valid && fwd_wb_rd == rs2));

    assign cmd_ready = !mem_stall && !rs1_haz && !rs2_haz;

    always_ff @(posedge clk) begin
        if (!rst_n)
            d_valid <= 1'b0;
        else if (!mem_stall)
            d_valid <= cmd_valid && cmd_ready;  // Bubble when nothing accepted
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            d_is_store <= is_store;
            d_size     <= size;
            d_signed   <= sgn;
            d_addr     <= addr;
            d_rd       <= is_store ? 5'd0 : instr.ld.rd;  // Stores name no destination
            d_rs2      <= is_store ? rs2 : 5'd0;
            d_rs2_val  <= cmd_rs2_val;
            d_fault    <= fault;
        end
    end

endmodule

/* design/lsu_mem_req.sv */
`timescale 1ns/1ps

module lsu_mem_req import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            d_valid,
    input  logic            d_is_store,
    input  logic [1:0]      d_size,
    input  logic            d_signed,
    input  logic [XLEN-1:0] d_addr,
    input  logic [4:0]      d_rd,
    input  logic [4:0]      d_rs2,
    input  logic [XLEN-1:0] d_rs2_val,
    input  logic [1:0]      d_fault,
    input  logic            dmem_ack,
    input  logic [XLEN-1:0] dmem_rdata,
    input  logic            fwd_rsp_valid,
    input  logic [4:0]      fwd_rsp_rd,
    input  logic [XLEN-1:0] fwd_rsp_val,
    input  logic            fwd_wb_valid,
    input  logic [4:0]      fwd_wb_rd,
    input  logic [XLEN-1:0] fwd_wb_val,
    output logic            mem_stall,
    output logic            pend_req_valid,
    output logic [4:0]      pend_req_rd,
    output logic            dmem_req,
    output logic [XLEN-1:0] dmem_addr,
    output logic            dmem_we,
    output logic [3:0]      dmem_be,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            r_valid,
    output logic            r_is_store,
    output logic [1:0]      r_size,
    output logic            r_signed,
    output logic [1:0]      r_addr_lo,
    output logic [4:0]      r_rd,
    output logic [XLEN-1:0] r_rdata,
    output logic [1:0]      r_fault
);
    logic            v_q;
    logic [1:0]      state_q;
    logic            is_store_q;
    logic [1:0]      size_q;
    logic            signed_q;
    logic [XLEN-1:0] addr_q;
    logic [4:0]      rd_q;
    logic [4:0]      rs2_q;
    logic [XLEN-1:0] rs2_val_q;
    logic [1:0]      fault_q;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] store_val;

    assign mem_stall = state_q == REQ_WAIT_ACK;  // Waiting for ack holds everything upstream

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_q     <= 1'b0;
            state_q <= REQ_IDLE;
        end else if (!mem_stall) begin
            v_q <= d_valid;
            // Clean entries raise req on their first cycle here
            state_q <= (d_valid && d_fault == FAULT_NONE) ? REQ_WAIT_ACK : REQ_IDLE;
        end else if (dmem_ack) begin
            state_q <= REQ_WAIT_LOW;  // Drop req, RAM drops ack as this entry leaves
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            is_store_q <= d_is_store;
            size_q     <= d_size;
            signed_q   <= d_signed;
            addr_q     <= d_addr;
            rd_q       <= d_rd;
            rs2_q      <= d_rs2;
            rs2_val_q  <= d_rs2_val;
            fault_q    <= d_fault;
        end else begin
            rs2_val_q <= store_val;  // Keep forwarded data after its source moves on
        end
        if (mem_stall && dmem_ack)
            rdata_q <= dmem_rdata;  // rdata only valid with ack
    end

    // Only older loads sit in rsp and wb, rsp is the younger one
    always_comb begin
        if (fwd_rsp_valid && fwd_rsp_rd == rs2_q)
            store_val = fwd_rsp_val;
        else if (fwd_wb_valid && fwd_wb_rd == rs2_q)
            store_val = fwd_wb_val;
        else
            store_val = rs2_val_q;
    end

    // Byte enables and replicated store lanes
    always_comb begin
        case (size_q)
            SIZE_BYTE: begin
                dmem_be    = 4'b0001 << addr_q[1:0];
                dmem_wdata = {4{store_val[7:0]}};
            end
            SIZE_HALF: begin
                dmem_be    = addr_q[1] ? 4'b1100 : 4'b0011;
                dmem_wdata = {2{store_val[15:0]}};
            end
            default: begin
                dmem_be    = 4'b1111;
                dmem_wdata = store_val;
            end
        endcase
    end

    assign dmem_req  = state_q == REQ_WAIT_ACK;
    assign dmem_addr = addr_q;
    assign dmem_we   = is_store_q;

    // Load destination for the decode hazard check
    assign pend_req_valid = v_q && !is_store_q && fault_q == FAULT_NONE;
    assign pend_req_rd    = rd_q;

    assign r_valid    = v_q && !mem_stall;
    assign r_is_store = is_store_q;
    assign r_size     = size_q;
    assign r_signed   = signed_q;
    assign r_addr_lo  = addr_q[1:0];
    assign r_rd       = rd_q;
    assign r_rdata    = rdata_q;
    assign r_fault    = fault_q;

endmodule

/* design/lsu_mem_rsp.sv */
`timescale 1ns/1ps

module lsu_mem_rsp import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            r_valid,
    input  logic            r_is_store,
    input  logic [1:0]      r_size,
    input  logic            r_signed,
    input  logic [1:0]      r_addr_lo,
    input  logic [4:0]      r_rd,
    input  logic [XLEN-1:0] r_rdata,
    input  logic [1:0]      r_fault,
    output logic            fwd_rsp_valid,
    output logic [4:0]      fwd_rsp_rd,
    output logic [XLEN-1:0] fwd_rsp_val,
    output logic            w_valid,
    output logic [4:0]      w_rd,
    output logic            w_we,
    output logic [XLEN-1:0] w_val,
    output logic [1:0]      w_fault
);
    logic            v_q;
    logic            is_store_q;
    logic [1:0]      size_q;
    logic            signed_q;
    logic [1:0]      addr_lo_q;
    logic [4:0]      rd_q;
    logic [XLEN-1:0] rdata_q;
    logic [1:0]      fault_q;
    logic [15:0]     sel_h;
    logic [7:0]      sel_b;
    logic [XLEN-1:0] ext_val;
    logic            ld_ok;

    // Never stalls, bubbles arrive while the request stage waits
    always_ff @(posedge clk) begin
        if (!rst_n)
            v_q <= 1'b0;
        else
            v_q <= r_valid;
    end

    always_ff @(posedge clk) begin
        is_store_q <= r_is_store;
        size_q     <= r_size;
        signed_q   <= r_signed;
        addr_lo_q  <= r_addr_lo;
        rd_q       <= r_rd;
        rdata_q    <= r_rdata;
        fault_q    <= r_fault;
    end

    assign sel_h = addr_lo_q[1] ? rdata_q[31:16] : rdata_q[15:0];  // Halfword by bit 1
    assign sel_b = addr_lo_q[0] ? sel_h[15:8] : sel_h[7:0];       // Then byte by bit 0

    always_comb begin
        case (size_q)
            SIZE_BYTE: ext_val = {{24{signed_q & sel_b[7]}}, sel_b};
            SIZE_HALF: ext_val = {{16{signed_q & sel_h[15]}}, sel_h};
            default:   ext_val = rdata_q;
        endcase
    end

    assign ld_ok = !is_store_q && fault_q == FAULT_NONE;

    assign w_valid = v_q;
    assign w_rd    = rd_q;
    assign w_we    = v_q && ld_ok && rd_q != 5'd0;  // x0 never written
    assign w_val   = ld_ok ? ext_val : '0;          // Stores and faults retire zero
    assign w_fault = fault_q;

    assign fwd_rsp_valid = w_we;
    assign fwd_rsp_rd    = rd_q;
    assign fwd_rsp_val   = ext_val;

endmodule

/* design/lsu_writeback.sv */
`timescale 1ns/1ps

module lsu_writeback import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            w_valid,
    input  logic [4:0]      w_rd,
    input  logic            w_we,
    input  logic [XLEN-1:0] w_val,
    input  logic [1:0]      w_fault,
    output logic            retire_valid,
    output logic [4:0]      retire_rd_idx,
    output logic [XLEN-1:0] retire_rd_val,
    output logic            retire_we,
    output logic [1:0]      retire_fault,
    output logic            fwd_wb_valid,
    output logic [4:0]      fwd_wb_rd,
    output logic [XLEN-1:0] fwd_wb_val
);
    logic            valid_q;
    logic            we_q;
    logic [4:0]      rd_q;
    logic [XLEN-1:0] val_q;
    logic [1:0]      fault_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= w_valid;
            we_q    <= w_we;  // Already qualified by w_valid
        end
    end

    always_ff @(posedge clk) begin
        rd_q    <= w_rd;
        val_q   <= w_val;
        fault_q <= w_fault;
    end

    assign retire_valid  = valid_q;
    assign retire_rd_idx = rd_q;
    assign retire_rd_val = val_q;
    assign retire_we     = we_q;
    assign retire_fault  = fault_q;

    // Issuer's register file lags this retire by a cycle
    assign fwd_wb_valid = we_q;
    assign fwd_wb_rd    = rd_q;
    assign fwd_wb_val   = val_q;

endmodule

/* design/lsu_data_ram.sv */
`timescale 1ns/1ps

module lsu_data_ram import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dmem_req,
    input  logic [XLEN-1:0] dmem_addr,
    input  logic            dmem_we,
    input  logic [3:0]      dmem_be,
    input  logic [XLEN-1:0] dmem_wdata,
    output logic            dmem_ack,
    output logic [XLEN-1:0] dmem_rdata
);
    logic [XLEN-1:0]                   mem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0]     widx;
    logic [$clog2(DMEM_LATENCY+1)-1:0] cnt;

    assign widx = dmem_addr[$clog2(DMEM_WORDS)+1:2];  // Upper address bits ignored

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_ack <= 1'b0;
            cnt      <= '0;
            for (int i = 0; i < DMEM_WORDS; i++)
                mem[i] <= '0;
        end else if (dmem_ack) begin
            if (!dmem_req)
                dmem_ack <= 1'b0;  // Return to zero
        end else if (dmem_req) begin
            // Count cycles since req rose
            if (cnt == DMEM_LATENCY - 1) begin
                cnt        <= '0;
                dmem_ack   <= 1'b1;
                dmem_rdata <= mem[widx];  // Old word on a write
                if (dmem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_be[b])
                            mem[widx][8*b +: 8] <= dmem_wdata[8*b +: 8];
                    end
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* design/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_valid,
    input  logic [XLEN-1:0] cmd_instr,
    input  logic [XLEN-1:0] cmd_rs1_val,
    input  logic [XLEN-1:0] cmd_rs2_val,
    output logic            cmd_ready,
    output logic            retire_valid,
    output logic [4:0]      retire_rd_idx,
    output logic [XLEN-1:0] retire_rd_val,
    output logic            retire_we,
    output logic [1:0]      retire_fault
);
    // Decode to request
    logic            d_valid;
    logic            d_is_store;
    logic [1:0]      d_size;
    logic            d_signed;
    logic [XLEN-1:0] d_addr;
    logic [4:0]      d_rd;
    logic [4:0]      d_rs2;
    logic [XLEN-1:0] d_rs2_val;
    logic [1:0]      d_fault;

    // Stall and hazard sources
    logic            mem_stall;
    logic            pend_req_valid;
    logic [4:0]      pend_req_rd;
    logic            fwd_rsp_valid;
    logic [4:0]      fwd_rsp_rd;
    logic [XLEN-1:0] fwd_rsp_val;
    logic            fwd_wb_valid;
    logic [4:0]      fwd_wb_rd;
    logic [XLEN-1:0] fwd_wb_val;

    // RAM four-phase port
    logic            dmem_req;
    logic [XLEN-1:0] dmem_addr;
    logic            dmem_we;
    logic [3:0]      dmem_be;
    logic [XLEN-1:0] dmem_wdata;
    logic            dmem_ack;
    logic [XLEN-1:0] dmem_rdata;

    // Request to response
    logic            r_valid;
    logic            r_is_store;
    logic [1:0]      r_size;
    logic            r_signed;
    logic [1:0]      r_addr_lo;
    logic [4:0]      r_rd;
    logic [XLEN-1:0] r_rdata;
    logic [1:0]      r_fault;

    // Response to writeback
    logic            w_valid;
    logic [4:0]      w_rd;
    logic            w_we;
    logic [XLEN-1:0] w_val;
    logic [1:0]      w_fault;

    // Port names match the wires one to one
    lsu_decode    decode_inst    (.*);
    lsu_mem_req   mem_req_inst   (.*);
    lsu_mem_rsp   mem_rsp_inst   (.*);
    lsu_writeback writeback_inst (.*);
    lsu_data_ram  data_ram_inst  (.*);

endmodule

/* sim/lsu_asserts.sv */
`timescale 1ns/1ps

module lsu_asserts import lsu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       dmem_req,
    input logic       dmem_ack,
    input logic       cmd_ready,
    input logic       mem_stall,
    input logic       retire_we,
    input logic [4:0] retire_rd_idx,
    input logic [1:0] retire_fault
);
    int unsigned fail_count = 0;  // Read by the testbench watcher

    // Four-phase, req held until the RAM answers
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ack |=> dmem_req)
        else begin
            $error("dmem_req dropped before dmem_ack");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_ack) |-> dmem_req)
        else begin
            $error("dmem_ack rose without dmem_req");
            fail_count++;
        end

    // Return to zero before the next access
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_req) |-> !dmem_ack)
        else begin
            $error("dmem_req rose while dmem_ack still high");
            fail_count++;
        end

    // Issue held off from req rise until ack is seen, then released
    stall_blocks_issue: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_stall) |-> !cmd_ready ##DMEM_LATENCY (mem_stall && !cmd_ready)
                             ##1 !mem_stall)
        else begin
            $error("cmd_ready high or mem_stall of wrong length during an access");
            fail_count++;
        end

    we_only_clean_rd: assert property (@(posedge clk) disable iff (!rst_n)
        retire_we |-> retire_rd_idx != 5'd0 && retire_fault == FAULT_NONE)
        else begin
            $error("retire_we with rd 0 or a fault");
            fail_count++;
        end

endmodule

bind lsu_top lsu_asserts lsu_asserts_inst (.*);

/* sim/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();
    logic            clk;
    logic            rst_n;
    logic            cmd_valid;
    logic [XLEN-1:0] cmd_instr;
    logic [XLEN-1:0] cmd_rs1_val;
    logic [XLEN-1:0] cmd_rs2_val;
    logic            cmd_ready;
    logic            retire_valid;
    logic [4:0]      retire_rd_idx;
    logic [XLEN-1:0] retire_rd_val;
    logic            retire_we;
    logic [1:0]      retire_fault;

    integer          seed;
    logic [31:0]     issuer_rf [32];   // Issuer's view, follows the retire ports
    logic [31:0]     model_rf [32];    // Program-order reference registers
    logic [7:0]      model_mem [1024]; // RAM ignores address bits above 9
    logic [2:0]      load_f3 [5];
    logic [4:0]      exp_rd [$];
    logic [31:0]     exp_val [$];
    logic            exp_we [$];
    logic [1:0]      exp_fault [$];

    lsu_top lsu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic report_mismatch(input string what);
        $display("CHECK FAILED at %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after a mismatch");
    endtask

    function automatic lsu_instr_u load_word(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        lsu_instr_u w;
        w.ld.opcode = OPC_LOAD;
        w.ld.funct3 = f3;
        w.ld.rd     = rd;
        w.ld.rs1    = rs1;
        w.ld.imm    = imm;
        return w;
    endfunction

    function automatic lsu_instr_u store_word(input logic [2:0] f3, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [11:0] imm);
        lsu_instr_u w;
        w.st.opcode = OPC_STORE;
        w.st.funct3 = f3;
        w.st.rs2    = rs2;
        w.st.rs1    = rs1;
        w.st.imm_hi = imm[11:5];  // S-type splits the offset
        w.st.imm_lo = imm[4:0];
        return w;
    endfunction

    // Sequential RV32I semantics, one command at a time
    task automatic predict(input lsu_instr_u ins);
        logic        is_ld;
        logic        is_st;
        logic        legal;
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] val;
        logic [1:0]  fault;
        logic [9:0]  idx;
        int          nbytes;
        int          i;
        f3    = ins.ld.funct3;
        is_ld = ins.ld.opcode == OPC_LOAD;
        is_st = ins.st.opcode == OPC_STORE;
        legal = (is_ld && f3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) ||
                (is_st && f3 inside {F3_B, F3_H, F3_W});
        imm   = is_st ? {{20{ins.st.imm_hi[6]}}, ins.st.imm_hi, ins.st.imm_lo}
                      : {{20{ins.ld.imm[11]}}, ins.ld.imm};
        addr   = model_rf[ins.ld.rs1] + imm;
        nbytes = 1 << f3[1:0];  // 1, 2 or 4 bytes
        if (!legal)
            fault = FAULT_ILLEGAL;
        else if ((addr & (nbytes - 1)) != 0)
            fault = FAULT_MISALIGNED;
        else
            fault = FAULT_NONE;
        val = '0;
        for (i = 0; i < nbytes && fault == FAULT_NONE; i++) begin
            idx = addr[9:0] + 10'(i);
            if (is_st)
                model_mem[idx] = model_rf[ins.st.rs2][8*i +: 8];
            else
                val[8*i +: 8] = model_mem[idx];
        end
        if (f3 == F3_B)
            val = {{24{val[7]}}, val[7:0]};
        else if (f3 == F3_H)
            val = {{16{val[15]}}, val[15:0]};
        exp_rd.push_back(ins.ld.rd);
        exp_val.push_back(val);
        exp_we.push_back(is_ld && fault == FAULT_NONE && ins.ld.rd != 5'd0);
        exp_fault.push_back(fault);
        if (is_ld && fault == FAULT_NONE && ins.ld.rd != 5'd0)
            model_rf[ins.ld.rd] = val;
    endtask

    // Offer one command until accepted, operands track retires meanwhile
    task automatic send_cmd(input lsu_instr_u ins);
        int waited;
        waited      = 0;
        cmd_valid   = 1'b1;
        cmd_instr   = ins;
        cmd_rs1_val = issuer_rf[ins.ld.rs1];
        cmd_rs2_val = issuer_rf[ins.st.rs2];
        @(negedge clk);
        while (!cmd_ready) begin
            waited++;
            if (waited > 100)
                abort_run("Timeout waiting for cmd_ready");
            @(posedge clk);
            #1;
            cmd_rs1_val = issuer_rf[ins.ld.rs1];
            cmd_rs2_val = issuer_rf[ins.st.rs2];
            @(negedge clk);
        end
        predict(ins);  // Accepted at the coming edge
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Retire checker, outputs settled by the falling edge
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            assert (exp_we.size() != 0)
                else abort_run("Retire arrived with no command outstanding");
            assert (retire_fault == exp_fault[0])
                else report_mismatch($sformatf("retire_fault %0d, expected %0d",
                                               retire_fault, exp_fault[0]));
            assert (retire_we == exp_we[0])
                else report_mismatch($sformatf("retire_we %0b, expected %0b",
                                               retire_we, exp_we[0]));
            if (exp_we[0]) begin
                assert (retire_rd_idx == exp_rd[0])
                    else report_mismatch($sformatf("retire_rd_idx %0d, expected %0d",
                                                   retire_rd_idx, exp_rd[0]));
                assert (retire_rd_val == exp_val[0])
                    else report_mismatch($sformatf("x%0d value %h, expected %h",
                                                   exp_rd[0], retire_rd_val, exp_val[0]));
            end
            if (retire_we)
                issuer_rf[retire_rd_idx] = retire_rd_val;  // Visible from the next cycle
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
            void'(exp_we.pop_front());
            void'(exp_fault.pop_front());
        end
    end

    always @(negedge clk) begin
        if (lsu_top_inst.lsu_asserts_inst.fail_count != 0)
            abort_run("A protocol assertion failed");
    end

    initial begin
        int          n;
        int          k;
        int          off;
        int          waited;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  base;
        seed        = 32'h603;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_instr   = '0;
        cmd_rs1_val = '0;
        cmd_rs2_val = '0;
        load_f3     = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
        for (k = 0; k < 1024; k++)
            model_mem[k] = 8'h00;
        issuer_rf[0] = '0;
        for (k = 1; k < 32; k++)
            issuer_rf[k] = (k <= 4) ? 32'(8 * k) : $random(seed);  // x1..x4 small bases
        for (k = 0; k < 32; k++)
            model_rf[k] = issuer_rf[k];

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (cmd_ready && !retire_valid)
            else report_mismatch("Wrong issue or retire state after reset");
        @(posedge clk);
        #1;

        // Every size stored, then every load kind at each offset
        send_cmd(store_word(F3_W, 5'd20, 5'd0, 12'd0));
        send_cmd(store_word(F3_W, 5'd21, 5'd0, 12'd4));
        send_cmd(store_word(F3_H, 5'd22, 5'd0, 12'd2));
        send_cmd(store_word(F3_B, 5'd23, 5'd0, 12'd5));
        for (off = 0; off < 8; off++)
            for (k = 0; k < 5; k++)
                send_cmd(load_word(load_f3[k], 5'(8 + k), 5'd0, 12'(off)));

        // Store data from the response stage, then from writeback
        send_cmd(load_word(F3_W, 5'd13, 5'd0, 12'd0));
        send_cmd(store_word(F3_W, 5'd13, 5'd0, 12'd32));
        send_cmd(load_word(F3_H, 5'd14, 5'd0, 12'd4));
        send_cmd(32'h0000_0033);  // Register op, one-cycle fault in between
        send_cmd(store_word(F3_W, 5'd14, 5'd0, 12'd36));
        send_cmd(load_word(F3_W, 5'd15, 5'd0, 12'd32));
        send_cmd(load_word(F3_W, 5'd16, 5'd0, 12'd36));

        // Base register from a load still in flight
        send_cmd(store_word(F3_W, 5'd1, 5'd0, 12'd40));
        send_cmd(load_word(F3_W, 5'd17, 5'd0, 12'd40));
        send_cmd(load_word(F3_W, 5'd18, 5'd17, 12'd0));
        send_cmd(load_word(F3_BU, 5'd19, 5'd17, 12'd3));

        // Faults leave memory untouched
        send_cmd(store_word(F3_H, 5'd20, 5'd0, 12'd13));
        send_cmd(store_word(F3_W, 5'd20, 5'd0, 12'd10));
        send_cmd(load_word(F3_W, 5'd21, 5'd0, 12'd2));
        send_cmd(load_word(F3_H, 5'd21, 5'd0, 12'd3));
        send_cmd(load_word(3'b011, 5'd21, 5'd0, 12'd0));   // No LD in RV32I
        send_cmd(store_word(F3_BU, 5'd20, 5'd0, 12'd8));   // No unsigned store
        send_cmd(load_word(F3_W, 5'd21, 5'd0, 12'd8));
        send_cmd(load_word(F3_W, 5'd22, 5'd0, 12'd12));

        // Random mix inside a 64-byte window
        for (n = 0; n < 400; n++) begin
            r    = $random(seed);
            imm  = {6'd0, r[21:16]};
            base = (r[3:2] == 2'd0) ? {3'b000, r[5:4]} + 5'd1 : 5'd0;
            if (r[1:0] == 2'd3 && r[12]) begin
                send_cmd({r[31:7], 7'b0110011});
            end else if (r[1]) begin
                f3 = (r[9:8] == 2'd3) ? F3_W : {1'b0, r[9:8]};
                if (r[11])
                    imm = imm & (12'hfff << f3[1:0]);  // Mostly aligned
                send_cmd(store_word(f3, r[31:27], base, imm));
            end else begin
                f3 = load_f3[r[10:8] % 5];
                if (r[11])
                    imm = imm & (12'hfff << f3[1:0]);
                send_cmd(load_word(f3, r[26:22], base, imm));
            end
            if (r[15:13] == 3'd0) begin  // Occasional idle cycle
                @(posedge clk);
                #1;
            end
        end

        waited = 0;
        while (exp_we.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 400)
                abort_run("Timeout waiting for outstanding commands to retire");
        end
        @(posedge clk);
        if (lsu_top_inst.lsu_asserts_inst.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Protocol assertions failed during the run");
        end
    end

endmodule

/* lsu.f */
design/lsu_pkg.sv
design/lsu_decode.sv
design/lsu_mem_req.sv
design/lsu_mem_rsp.sv
design/lsu_writeback.sv
design/lsu_data_ram.sv
design/lsu_top.sv
sim/lsu_asserts.sv
sim/lsu_tb.sv
